// ==== decoder.f ====
verilog/decoder_pkg.sv
verilog/opcode_classifier.sv
verilog/step_sequencer.sv
verilog/flag_unit.sv
verilog/control_word_gen.sv
verilog/decoder_top.sv
sim/decoder_sva.sv
sim/decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f decoder.f --top-module decoder_tb -o decoder_sim
output=$(./obj_dir/decoder_sim)
echo "$output"

if grep -q "all tests passed" <<< "$output"; then
        exit 0
fi
exit 1

// ==== sim/decoder_input.txt ====
// Stimulus: opcode imm_in status_in pc_in
// Expected: step 0 ctrl, last step ctrl, imm_out, jump_pc (all hex)
A9 42 00 0200 000160 000000 00 0242
AD 80 00 0200 000120 000000 00 0180
A2 7F 24 0200 000150 000000 24 027F
A6 01 24 0200 000110 000000 24 0201
A0 FF 80 0200 000148 000000 80 01FF
AC 10 80 0200 000108 000000 80 0210
85 20 03 0400 000042 000000 03 0420
8E E0 03 0400 000082 000000 03 03E0
84 05 C1 0400 0000C2 000000 C1 0405
09 0F 00 0300 22A000 0005A4 00 030F
2D 33 02 0300 428000 0005A4 02 0333
49 FF 00 0300 62A000 0005A4 00 02FF
69 01 01 0300 82B000 0005A4 01 0301
E5 81 80 0300 828800 0005A4 80 0281
C9 40 00 0300 82B800 000584 00 0340
E0 10 01 0300 84B800 000584 01 0310
CC 20 00 0300 869800 000584 00 0320
18 00 FF 0100 000144 000000 FE 0100
38 00 00 0100 000144 000000 01 0100
58 00 FF 0100 000144 000000 FB 0100
78 00 00 0100 000144 000000 04 0100
B8 00 FF 0100 000144 000000 BF 0100
D8 00 FF 0100 000144 000000 F7 0100
F8 00 00 0100 000144 000000 08 0100
10 10 80 1000 000000 000000 80 1010
10 F0 00 1000 000001 000000 00 0FF0
30 10 80 1000 000001 000000 80 1010
30 F0 00 1000 000000 000000 00 0FF0
50 7F 40 2000 000000 000000 40 207F
50 80 00 2000 000001 000000 00 1F80
70 7F 40 2000 000001 000000 40 207F
70 80 00 2000 000000 000000 00 1F80
90 08 01 FFF8 000000 000000 01 0000
90 FE 00 0004 000001 000000 00 0002
B0 08 01 FFF8 000001 000000 01 0000
B0 FE 00 0004 000000 000000 00 0002
D0 20 02 8000 000000 000000 02 8020
D0 E0 00 8000 000001 000000 00 7FE0
F0 20 02 8000 000001 000000 02 8020
F0 E0 00 8000 000000 000000 00 7FE0
EA 12 5A 0500 000000 000000 5A 0512
00 F0 A5 0500 000000 000000 A5 04F0

// ==== sim/decoder_sva.sv ====
/* Decoder protocol assertions
   Checks done, busy, idle control and write enable exclusivity */

`timescale 1ns/100ps

module decoder_sva import decoder_pkg::*; (
        input logic  clk,
        input logic  reset_n,
        input logic  busy,
        input logic  done,
        input ctrl_t ctrl
);

        done_single: assert property (@(posedge clk) disable iff (!reset_n)
                done |=> !done)
                else $error("done stayed high for more than one cycle");

        // Never in the accepting cycle
        done_busy: assert property (@(posedge clk) disable iff (!reset_n)
                done |-> busy && $past(busy))
                else $error("done high while busy is low or just rose");

        idle_ctrl: assert property (@(posedge clk) disable iff (!reset_n)
                !busy |-> (ctrl == '0))
                else $error("control word not empty while idle");

        // Status write may join a register write
        one_write: assert property (@(posedge clk) disable iff (!reset_n)
                $onehot0({ctrl.we.acc, ctrl.we.x, ctrl.we.y, ctrl.we.dout}))
                else $error("more than one register or memory write enable");

endmodule

bind decoder_top decoder_sva sva0 (
        .clk     (clk),
        .reset_n (reset_n),
        .busy    (busy),
        .done    (done),
        .ctrl    (ctrl)
);

// ==== sim/decoder_tb.sv ====
/* Instruction decoder testbench
   Runs file driven vectors through decoder_top and checks each step */

`timescale 1ns/100ps

module decoder_tb import decoder_pkg::*; ();

        localparam int    CLK_PERIOD        = 8;
        localparam int    RESET_CYCLES      = 8;
        localparam int    CYCLES_PER_VECTOR = 10;
        localparam int    ALU_DELAY_MAX     = 5;
        localparam string VECTOR_FILE       = "sim/decoder_input.txt";

        typedef struct packed {
                logic [REG_WIDTH-1:0]  opcode;
                logic [REG_WIDTH-1:0]  imm;
                logic [REG_WIDTH-1:0]  status;
                logic [ADDR_WIDTH-1:0] pc;
                ctrl_t                 ctrl_first;  // Step 0
                ctrl_t                 ctrl_last;   // Done cycle
                logic [REG_WIDTH-1:0]  imm_out;
                logic [ADDR_WIDTH-1:0] jump_pc;
        } vector_t;

        logic                  clk;
        logic                  reset_n;
        logic                  instruction_ready;
        logic [REG_WIDTH-1:0]  instruction_in;
        logic [REG_WIDTH-1:0]  imm_in;
        logic [ADDR_WIDTH-1:0] pc_in;
        logic [REG_WIDTH-1:0]  status_in;
        logic                  alu_done;
        ctrl_t                 ctrl;
        logic [REG_WIDTH-1:0]  imm_out;
        logic [ADDR_WIDTH-1:0] jump_pc;
        logic                  busy;
        logic                  done;

        vector_t vectors[$];
        int      error_count  = 0;
        int      failed_tests = 0;
        bit      loaded       = 1'b0;
        integer  seed         = 97;

        decoder_top dut0 (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .imm_in            (imm_in),
                .pc_in             (pc_in),
                .status_in         (status_in),
                .alu_done          (alu_done),
                .ctrl              (ctrl),
                .imm_out           (imm_out),
                .jump_pc           (jump_pc),
                .busy              (busy),
                .done              (done)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
                if (got !== exp) begin
                        $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
                        error_count++;
                end
        endtask

        task automatic check_byte(input logic [REG_WIDTH-1:0] got,
                                  input logic [REG_WIDTH-1:0] exp, input string what);
                if (got !== exp) begin
                        $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
                        error_count++;
                end
        endtask

        task automatic check_addr(input logic [ADDR_WIDTH-1:0] got,
                                  input logic [ADDR_WIDTH-1:0] exp, input string what);
                if (got !== exp) begin
                        $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
                        error_count++;
                end
        endtask

        task automatic report_problem(input string what);
                $display("At %0t: %s", $time, what);
                error_count++;
        endtask

        task automatic load_vectors();
                integer                    fd;
                integer                    code;
                string                     line;
                logic [REG_WIDTH-1:0]      op, imm, stat, out;
                logic [ADDR_WIDTH-1:0]     pc, target;
                logic [$bits(ctrl_t)-1:0]  first, last;
                vector_t                   v;
                fd = $fopen(VECTOR_FILE, "r");
                if (fd == 0) begin
                        report_problem("the vector file could not be opened");
                end else begin
                        while (!$feof(fd)) begin
                                line = "";
                                code = $fgets(line, fd);
                                if (code != 0) begin
                                        code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                                       op, imm, stat, pc, first, last, out, target);
                                        if (code == 8) begin  // Comment lines do not scan
                                                v.opcode     = op;
                                                v.imm        = imm;
                                                v.status     = stat;
                                                v.pc         = pc;
                                                v.ctrl_first = ctrl_t'(first);
                                                v.ctrl_last  = ctrl_t'(last);
                                                v.imm_out    = out;
                                                v.jump_pc    = target;
                                                vectors.push_back(v);
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        task automatic check_reset_idle();
                int errs_before;
                errs_before = error_count;
                repeat (2) begin
                        @(negedge clk);
                        if (busy !== 1'b0 || done !== 1'b0)
                                report_problem("busy or done is high before the first instruction");
                        check_ctrl(ctrl, '0, "idle control");
                end
                if (error_count != errs_before)
                        failed_tests++;
                $display("test 0 reset idle: %s", (error_count == errs_before) ? "ok" : "mismatch");
        endtask

        // Entered and left on a falling edge
        task automatic run_vector(input vector_t v, input int idx);
                int errs_before;
                int delay;
                bit alu;
                errs_before = error_count;
                alu = (v.ctrl_first.alu_op != ALU_NONE);
                instruction_in    = v.opcode;
                imm_in            = v.imm;
                status_in         = v.status;
                pc_in             = v.pc;
                instruction_ready = 1'b1;
                @(negedge clk);  // Step 0
                check_ctrl(ctrl, v.ctrl_first, "step 0 control");
                check_byte(imm_out, v.imm_out, "imm_out");
                check_addr(jump_pc, v.jump_pc, "jump_pc");
                if (!busy)
                        report_problem("busy did not rise after the accepting edge");
                if (done)
                        report_problem("done came early, in step 0");
                instruction_in = ~v.opcode;  // Strobe held while busy
                alu_done       = !alu;       // Stray alu_done outside ALU step 1
                @(negedge clk);  // Step 1
                alu_done = 1'b0;
                if (alu) begin
                        delay = $unsigned($random(seed)) % (ALU_DELAY_MAX + 1);
                        for (int i = 0; i <= delay; i++) begin
                                if (i != 0)
                                        @(negedge clk);
                                if (done)
                                        report_problem("done came before alu_done");
                                check_ctrl(ctrl, '0, "stall control");
                        end
                        alu_done = 1'b1;
                        @(negedge clk);
                        alu_done = 1'b0;
                end
                if (!done)
                        report_problem("done is missing in the last step");
                check_ctrl(ctrl, v.ctrl_last, "last step control");
                @(negedge clk);
                if (done || busy)
                        report_problem("an extra done or busy followed the last step");
                instruction_ready = 1'b0;
                if (error_count != errs_before)
                        failed_tests++;
                $display("test %0d opcode %h: %s", idx, v.opcode,
                         (error_count == errs_before) ? "ok" : "mismatch");
        endtask

        initial begin
                reset_n           = 1'b0;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                imm_in            = '0;
                pc_in             = '0;
                status_in         = '0;
                alu_done          = 1'b0;
                load_vectors();
                loaded = 1'b1;
                if (vectors.size() == 0) begin
                        report_problem("no test vectors were read");
                end else begin
                        repeat (RESET_CYCLES) @(negedge clk);
                        reset_n = 1'b1;
                        check_reset_idle();
                        foreach (vectors[i])
                                run_vector(vectors[i], i + 1);
                end
                $display("%0d vectors run, %0d tests with errors, %0d errors in total",
                         vectors.size(), failed_tests, error_count);
                if (error_count == 0)
                        $display("all tests passed");
                else
                        $display("tests failed");
                $finish;
        end

        // Watchdog
        initial begin
                wait (loaded);
                repeat (RESET_CYCLES + vectors.size() * CYCLES_PER_VECTOR) @(posedge clk);
                $display("Timeout: the vectors did not complete in the allowed time");
                $display("tests failed");
                $finish;
        end

endmodule

// ==== verilog/control_word_gen.sv ====
/* Control word generator
   Builds the per step control word from the latched instruction */

`timescale 1ns/100ps

module control_word_gen import decoder_pkg::*; (
        input  decode_t               dec,
        input  logic [STEP_WIDTH-1:0] step,
        input  logic                  busy,
        input  logic                  taken,
        output ctrl_t                 ctrl
);

        // Write enable of the working register
        function automatic we_t reg_we(input sel_e r);
                we_t w;
                w     = '0;
                w.acc = (r == SEL_ACC);
                w.x   = (r == SEL_X);
                w.y   = (r == SEL_Y);
                return w;
        endfunction

        always_comb begin
                ctrl = '0;
                if (busy) begin
                        case (dec.cls)
                                CLS_ALU: begin
                                        if (step == 2'd0) begin  // Issue
                                                ctrl.alu_op   = dec.alu_op;
                                                ctrl.alu_a    = dec.reg_sel;
                                                ctrl.alu_b    = dec.operand_sel;
                                                ctrl.carry_in = dec.use_carry ? taken : dec.is_compare;
                                                ctrl.invert_b = dec.invert_b;
                                        end else if (step == 2'd2) begin  // Write back
                                                ctrl.wr_sel        = SEL_ALU;
                                                ctrl.update_status = 1'b1;
                                                if (!dec.is_compare)
                                                        ctrl.we = reg_we(dec.reg_sel);
                                                ctrl.we.stat = 1'b1;
                                        end
                                end
                                CLS_LOAD: begin
                                        if (step == 2'd0) begin
                                                ctrl.we     = reg_we(dec.reg_sel);
                                                ctrl.wr_sel = dec.operand_sel;
                                        end
                                end
                                CLS_STORE: begin
                                        if (step == 2'd0) begin
                                                ctrl.we.dout = 1'b1;
                                                ctrl.wr_sel  = dec.reg_sel;
                                        end
                                end
                                CLS_FLAG: begin
                                        if (step == 2'd0) begin
                                                ctrl.we.stat = 1'b1;
                                                ctrl.wr_sel  = SEL_IMM;  // New status on imm_out
                                        end
                                end
                                CLS_BRANCH: begin
                                        if (step == 2'd0)
                                                ctrl.we.pc = taken;
                                end
                                default: ;
                        endcase
                end
        end

endmodule

// ==== verilog/decoder_pkg.sv ====
/* Instruction decoder package
   Widths, status flag positions, decode enums and the control word structs */

package decoder_pkg;

        localparam int REG_WIDTH  = 8;
        localparam int ADDR_WIDTH = 16;
        localparam int STEP_WIDTH = 2;

        // Status register bit positions
        localparam logic [2:0] FLAG_C = 3'd0;
        localparam logic [2:0] FLAG_Z = 3'd1;
        localparam logic [2:0] FLAG_I = 3'd2;
        localparam logic [2:0] FLAG_D = 3'd3;
        localparam logic [2:0] FLAG_V = 3'd6;
        localparam logic [2:0] FLAG_N = 3'd7;

        typedef enum logic [2:0] {
                CLS_NOP    = 3'd0,
                CLS_ALU    = 3'd1,
                CLS_LOAD   = 3'd2,
                CLS_STORE  = 3'd3,
                CLS_FLAG   = 3'd4,
                CLS_BRANCH = 3'd5
        } instr_class_e;

        typedef enum logic [2:0] {
                ALU_NONE = 3'd0,
                ALU_OR   = 3'd1,
                ALU_AND  = 3'd2,
                ALU_XOR  = 3'd3,
                ALU_SUM  = 3'd4
        } alu_op_e;

        // Data sources for ALU inputs and write back
        typedef enum logic [3:0] {
                SEL_NONE = 4'd0,
                SEL_ACC  = 4'd1,
                SEL_X    = 4'd2,
                SEL_Y    = 4'd3,
                SEL_MEM  = 4'd4,
                SEL_IMM  = 4'd5,
                SEL_ALU  = 4'd6,
                SEL_STAT = 4'd7
        } sel_e;

        typedef struct packed {
                logic acc;
                logic x;
                logic y;
                logic stat;
                logic dout;
                logic pc;
        } we_t;

        typedef struct packed {
                instr_class_e cls;
                alu_op_e      alu_op;
                sel_e         reg_sel;      // Working register
                sel_e         operand_sel;  // SEL_IMM or SEL_MEM
                logic         invert_b;
                logic         use_carry;    // Carry in taken from status
                logic         is_compare;
                logic [2:0]   flag_index;
                logic         flag_value;
        } decode_t;

        typedef struct packed {
                alu_op_e alu_op;
                sel_e    alu_a;
                sel_e    alu_b;
                logic    carry_in;
                logic    invert_b;
                logic    update_status;
                sel_e    wr_sel;
                we_t     we;
        } ctrl_t;

endpackage

// ==== verilog/decoder_top.sv ====
/* Instruction decoder top level
   Connects classifier, step sequencer, flag unit and control word generator */

`timescale 1ns/100ps

module decoder_top import decoder_pkg::*; (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  instruction_ready,
        input  logic [REG_WIDTH-1:0]  instruction_in,
        input  logic [REG_WIDTH-1:0]  imm_in,
        input  logic [ADDR_WIDTH-1:0] pc_in,
        input  logic [REG_WIDTH-1:0]  status_in,
        input  logic                  alu_done,
        output ctrl_t                 ctrl,
        output logic [REG_WIDTH-1:0]  imm_out,
        output logic [ADDR_WIDTH-1:0] jump_pc,
        output logic                  busy,
        output logic                  done
);

        decode_t               dec_next;
        decode_t               dec;
        logic [STEP_WIDTH-1:0] step;
        logic                  taken;

        opcode_classifier classifier0 (
                .instruction_in (instruction_in),
                .dec_next       (dec_next)
        );

        step_sequencer sequencer0 (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .dec_next          (dec_next),
                .alu_done          (alu_done),
                .dec               (dec),
                .step              (step),
                .busy              (busy),
                .done              (done)
        );

        flag_unit flags0 (
                .dec       (dec),
                .status_in (status_in),
                .pc_in     (pc_in),
                .imm_in    (imm_in),
                .taken     (taken),
                .jump_pc   (jump_pc),
                .imm_out   (imm_out)
        );

        control_word_gen ctrl_gen0 (
                .dec   (dec),
                .step  (step),
                .busy  (busy),
                .taken (taken),
                .ctrl  (ctrl)
        );

endmodule

// ==== verilog/flag_unit.sv ====
/* Flag unit
   Tests a status flag, forms the branch target and rewrites flags for SEx/CLx */

`timescale 1ns/100ps

module flag_unit import decoder_pkg::*; (
        input  decode_t               dec,
        input  logic [REG_WIDTH-1:0]  status_in,
        input  logic [ADDR_WIDTH-1:0] pc_in,
        input  logic [REG_WIDTH-1:0]  imm_in,
        output logic                  taken,
        output logic [ADDR_WIDTH-1:0] jump_pc,
        output logic [REG_WIDTH-1:0]  imm_out
);

        logic [ADDR_WIDTH-1:0] offset;

        // Also yields the status carry for ADC and SBC
        assign taken = (status_in[dec.flag_index] == dec.flag_value);

        assign offset  = {{(ADDR_WIDTH-REG_WIDTH){imm_in[REG_WIDTH-1]}}, imm_in};
        assign jump_pc = pc_in + offset;

        always_comb begin
                imm_out = status_in;
                if (dec.cls == CLS_FLAG)
                        imm_out[dec.flag_index] = dec.flag_value;  // Force one bit
        end

endmodule

// ==== verilog/opcode_classifier.sv ====
/* Opcode classifier
   Splits a 6502 opcode into class, ALU operation, register and operand source */

`timescale 1ns/100ps

module opcode_classifier import decoder_pkg::*; (
        input  logic [REG_WIDTH-1:0] instruction_in,
        output decode_t              dec_next
);

        logic [1:0] grp;
        logic [2:0] op;
        logic [2:0] mode;

        assign grp  = instruction_in[1:0];
        assign op   = instruction_in[7:5];
        assign mode = instruction_in[4:2];

        always_comb begin
                dec_next = '0;
                case (grp)
                        2'b01: begin
                                dec_next.reg_sel     = SEL_ACC;
                                dec_next.operand_sel = (mode == 3'b010) ? SEL_IMM : SEL_MEM;
                                case (op)
                                        3'b100: if (mode != 3'b010) dec_next.cls = CLS_STORE;  // No STA #imm
                                        3'b101: dec_next.cls = CLS_LOAD;
                                        default: begin
                                                dec_next.cls        = CLS_ALU;
                                                dec_next.invert_b   = (op == 3'b110) || (op == 3'b111);
                                                dec_next.use_carry  = (op == 3'b011) || (op == 3'b111);
                                                dec_next.is_compare = (op == 3'b110);
                                                case (op)
                                                        3'b000:  dec_next.alu_op = ALU_OR;
                                                        3'b001:  dec_next.alu_op = ALU_AND;
                                                        3'b010:  dec_next.alu_op = ALU_XOR;
                                                        default: dec_next.alu_op = ALU_SUM;
                                                endcase
                                        end
                                endcase
                        end
                        2'b10: begin
                                dec_next.reg_sel     = SEL_X;
                                dec_next.operand_sel = (mode == 3'b000) ? SEL_IMM : SEL_MEM;
                                if (op == 3'b100 && mode[0] && mode != 3'b111)
                                        dec_next.cls = CLS_STORE;
                                else if (op == 3'b101 && (mode[0] || mode == 3'b000))
                                        dec_next.cls = CLS_LOAD;
                        end
                        2'b00: begin
                                if (mode == 3'b100) begin
                                        dec_next.cls        = CLS_BRANCH;
                                        dec_next.flag_value = instruction_in[5];
                                        case (instruction_in[7:6])
                                                2'b00:   dec_next.flag_index = FLAG_N;
                                                2'b01:   dec_next.flag_index = FLAG_V;
                                                2'b10:   dec_next.flag_index = FLAG_C;
                                                default: dec_next.flag_index = FLAG_Z;
                                        endcase
                                end else if (mode == 3'b110) begin
                                        dec_next.cls        = CLS_FLAG;
                                        dec_next.flag_value = op[0];  // Odd rows set
                                        case (op)
                                                3'b000, 3'b001: dec_next.flag_index = FLAG_C;
                                                3'b010, 3'b011: dec_next.flag_index = FLAG_I;
                                                3'b101: begin
                                                        dec_next.flag_index = FLAG_V;
                                                        dec_next.flag_value = 1'b0;
                                                end
                                                3'b110, 3'b111: dec_next.flag_index = FLAG_D;
                                                default: dec_next.cls = CLS_NOP;  // TYA
                                        endcase
                                end else begin
                                        dec_next.reg_sel     = (op == 3'b111) ? SEL_X : SEL_Y;
                                        dec_next.operand_sel = (mode == 3'b000) ? SEL_IMM : SEL_MEM;
                                        if (op == 3'b100 && mode[0] && mode != 3'b111) begin
                                                dec_next.cls = CLS_STORE;
                                        end else if (op == 3'b101 && (mode[0] || mode == 3'b000)) begin
                                                dec_next.cls = CLS_LOAD;
                                        end else if (op[2:1] == 2'b11 && !mode[2] && mode != 3'b010) begin
                                                dec_next.cls        = CLS_ALU;  // CPY, CPX
                                                dec_next.alu_op     = ALU_SUM;
                                                dec_next.invert_b   = 1'b1;
                                                dec_next.is_compare = 1'b1;
                                        end
                                end
                        end
                        default: ;
                endcase

                if (dec_next.cls == CLS_NOP)
                        dec_next = '0;
                else if (dec_next.use_carry) begin
                        dec_next.flag_index = FLAG_C;  // Carry test shares the flag compare
                        dec_next.flag_value = 1'b1;
                end
        end

endmodule

// ==== verilog/step_sequencer.sv ====
/* Step sequencer
   Holds the accepted instruction, counts its steps and signals busy and done */

`timescale 1ns/100ps

module step_sequencer import decoder_pkg::*; (
        input  logic                  clk,
        input  logic                  reset_n,
        input  logic                  instruction_ready,
        input  decode_t               dec_next,
        input  logic                  alu_done,
        output decode_t               dec,
        output logic [STEP_WIDTH-1:0] step,
        output logic                  busy,
        output logic                  done
);

        logic alu_class;
        logic last_step;
        logic advance;

        assign alu_class = (dec.cls == CLS_ALU);
        assign last_step = alu_class ? (step == 2'd2) : (step == 2'd1);
        assign done      = busy & last_step;

        // ALU class waits in step 1 for the ALU
        assign advance = (step != 2'd1) || !alu_class || alu_done;

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        busy <= 1'b0;
                        step <= '0;
                        dec  <= '0;
                end else if (!busy) begin
                        if (instruction_ready) begin  // Accepting edge
                                dec  <= dec_next;
                                step <= '0;
                                busy <= 1'b1;
                        end
                end else if (last_step) begin
                        busy <= 1'b0;
                        step <= '0;
                end else if (advance) begin
                        step <= step + 1'b1;
                end
        end

endmodule
